// File: Bender.yml
package:
  name: ipu_cc

sources:
  # RTL in compile order
  - files:
      - hdl/ipu_pkg.sv
      - hdl/spill_register.sv
      - hdl/ipu_muldiv.sv
      - hdl/offload_counters.sv
      - hdl/ipu_cc.sv

  # Testbench
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/ipu_cc_checker.sv
      - verif/ipu_cc_tb.sv

// File: hdl/ipu_cc.sv
// Offload complex top level with request/response spill registers,
// the multiply/divide unit and the offload event counters

`timescale 1ns/1ps

module ipu_cc import ipu_pkg::*; #(
  parameter bit RegisterOffloadReq  = 1'b1,
  parameter bit RegisterOffloadResp = 1'b1
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // Offload request
  input  ipu_op_e               offload_qop_i,
  input  logic [31:0]           offload_qarga_i,
  input  logic [31:0]           offload_qargb_i,
  input  logic [IdWidth-1:0]    offload_qid_i,
  input  logic                  offload_qvalid_i,
  output logic                  offload_qready_o,
  // Offload response
  output logic [31:0]           offload_pdata_o,
  output logic [IdWidth-1:0]    offload_pid_o,
  output logic                  offload_pvalid_o,
  input  logic                  offload_pready_i,
  // Counters
  input  logic                  cnt_clear_i,
  output logic [CountWidth-1:0] cnt_req_o,
  output logic [CountWidth-1:0] cnt_resp_o,
  output logic [CountWidth-1:0] cnt_stall_o
);

  logic [ReqWidth-1:0]  acc_req_d, acc_req_q;
  logic [RespWidth-1:0] acc_resp_d, acc_resp_q;
  logic                 acc_req_q_valid, acc_req_q_ready;
  logic                 acc_resp_d_valid, acc_resp_d_ready;
  ipu_op_e              acc_qop;
  logic [31:0]          acc_qarga, acc_qargb, acc_pdata;
  logic [IdWidth-1:0]   acc_qid, acc_pid;

  assign acc_req_d = {offload_qop_i, offload_qarga_i, offload_qargb_i, offload_qid_i};

  // Cut the request path
  spill_register #(
    .Width  ( ReqWidth            ),
    .Bypass ( !RegisterOffloadReq )
  ) i_spill_register_acc_req (
    .clk_i   ( clk_i            ),
    .rst_i   ( rst_i            ),
    .valid_i ( offload_qvalid_i ),
    .data_i  ( acc_req_d        ),
    .ready_o ( offload_qready_o ),
    .valid_o ( acc_req_q_valid  ),
    .data_o  ( acc_req_q        ),
    .ready_i ( acc_req_q_ready  )
  );

  assign acc_qop   = ipu_op_e'(acc_req_q[ReqWidth-1 -: 3]);
  assign acc_qarga = acc_req_q[IdWidth+63 -: 32];
  assign acc_qargb = acc_req_q[IdWidth+31 -: 32];
  assign acc_qid   = acc_req_q[IdWidth-1:0];

  ipu_muldiv i_ipu_muldiv (
    .clk_i    ( clk_i            ),
    .rst_i    ( rst_i            ),
    .qop_i    ( acc_qop          ),
    .qarga_i  ( acc_qarga        ),
    .qargb_i  ( acc_qargb        ),
    .qid_i    ( acc_qid          ),
    .qvalid_i ( acc_req_q_valid  ),
    .qready_o ( acc_req_q_ready  ),
    .pdata_o  ( acc_pdata        ),
    .pid_o    ( acc_pid          ),
    .pvalid_o ( acc_resp_d_valid ),
    .pready_i ( acc_resp_d_ready )
  );

  assign acc_resp_d = {acc_pdata, acc_pid};

  // Cut the response path
  spill_register #(
    .Width  ( RespWidth            ),
    .Bypass ( !RegisterOffloadResp )
  ) i_spill_register_acc_resp (
    .clk_i   ( clk_i            ),
    .rst_i   ( rst_i            ),
    .valid_i ( acc_resp_d_valid ),
    .data_i  ( acc_resp_d       ),
    .ready_o ( acc_resp_d_ready ),
    .valid_o ( offload_pvalid_o ),
    .data_o  ( acc_resp_q       ),
    .ready_i ( offload_pready_i )
  );

  assign offload_pdata_o = acc_resp_q[RespWidth-1 -: 32];
  assign offload_pid_o   = acc_resp_q[IdWidth-1:0];

  // Events seen at the core-side handshake
  offload_counters i_offload_counters (
    .clk_i       ( clk_i                                  ),
    .rst_i       ( rst_i                                  ),
    .req_fire_i  ( offload_qvalid_i && offload_qready_o   ),
    .req_stall_i ( offload_qvalid_i && !offload_qready_o  ),
    .resp_fire_i ( offload_pvalid_o && offload_pready_i   ),
    .cnt_clear_i ( cnt_clear_i                            ),
    .cnt_req_o   ( cnt_req_o                              ),
    .cnt_resp_o  ( cnt_resp_o                             ),
    .cnt_stall_o ( cnt_stall_o                            )
  );

endmodule

// File: hdl/ipu_muldiv.sv
// RV32M multiply/divide unit with a two-stage multiplier,
// a serial restoring divider and a shared response register

`timescale 1ns/1ps

module ipu_muldiv import ipu_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_i,
  input  ipu_op_e            qop_i,
  input  logic [31:0]        qarga_i,
  input  logic [31:0]        qargb_i,
  input  logic [IdWidth-1:0] qid_i,
  input  logic               qvalid_i,
  output logic               qready_o,
  output logic [31:0]        pdata_o,
  output logic [IdWidth-1:0] pid_o,
  output logic               pvalid_o,
  input  logic               pready_i
);

  typedef enum logic [1:0] {IDLE, DIV_RUN, DIV_DONE} div_state_e;

  div_state_e         state_q;
  logic [4:0]         cnt_q;
  logic               op_is_div, mul_fire, div_fire, resp_free;
  // Multiply stage 1
  logic               m1_valid_q, m1_high_q;
  logic [32:0]        m1_a_q, m1_b_q;
  logic [IdWidth-1:0] m1_id_q;
  logic signed [65:0] mul_prod;
  logic [31:0]        mul_result;
  // Divider datapath
  logic [31:0]        quo_q, rem_q, divisor_q;
  logic               neg_quo_q, neg_rem_q, is_rem_q, div_zero_q;
  logic [IdWidth-1:0] div_id_q;
  logic               div_signed, div_a_neg, div_b_neg;
  logic [32:0]        div_shift;
  logic [33:0]        div_diff;
  logic [31:0]        div_quo, div_rem, div_result;
  // Response register
  logic               resp_valid_q;
  logic [31:0]        resp_data_q;
  logic [IdWidth-1:0] resp_id_q;

  // ------------------------------------------------------------
  // Issue control
  // ------------------------------------------------------------
  assign op_is_div = qop_i inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
  assign resp_free = !resp_valid_q || pready_i;

  // Divisions wait for an empty multiply pipeline to keep order
  assign qready_o = (state_q == IDLE) && resp_free && !(op_is_div && m1_valid_q);
  assign mul_fire = qvalid_i && qready_o && !op_is_div;
  assign div_fire = qvalid_i && qready_o && op_is_div;

  // ------------------------------------------------------------
  // Multiplier
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      m1_valid_q <= 1'b0;
    end else if (resp_free) begin
      m1_valid_q <= mul_fire;
    end
  end

  // Sign extension picks signed/unsigned per operand
  always_ff @(posedge clk_i) begin
    if (mul_fire) begin
      m1_a_q    <= {(qop_i inside {OP_MULH, OP_MULHSU}) && qarga_i[31], qarga_i};
      m1_b_q    <= {(qop_i == OP_MULH) && qargb_i[31], qargb_i};
      m1_high_q <= (qop_i != OP_MUL);
      m1_id_q   <= qid_i;
    end
  end

  assign mul_prod   = $signed(m1_a_q) * $signed(m1_b_q);
  assign mul_result = m1_high_q ? mul_prod[63:32] : mul_prod[31:0];

  // ------------------------------------------------------------
  // Divider
  // ------------------------------------------------------------
  assign div_signed = qop_i inside {OP_DIV, OP_REM};
  assign div_a_neg  = div_signed && qarga_i[31];
  assign div_b_neg  = div_signed && qargb_i[31];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (div_fire) begin
            state_q <= DIV_RUN;
            cnt_q   <= '0;
          end
        end
        DIV_RUN: begin
          cnt_q <= cnt_q + 5'd1;
          if (cnt_q == 5'd31) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (resp_free) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // One quotient bit per cycle, dividend shifts out of quo_q
  assign div_shift = {rem_q, quo_q[31]};
  assign div_diff  = {1'b0, div_shift} - {2'b00, divisor_q};

  always_ff @(posedge clk_i) begin
    if (div_fire) begin
      quo_q      <= div_a_neg ? -qarga_i : qarga_i;
      divisor_q  <= div_b_neg ? -qargb_i : qargb_i;
      rem_q      <= '0;
      neg_quo_q  <= div_a_neg ^ div_b_neg;
      neg_rem_q  <= div_a_neg;
      is_rem_q   <= qop_i inside {OP_REM, OP_REMU};
      div_zero_q <= (qargb_i == 32'd0);
      div_id_q   <= qid_i;
    end else if (state_q == DIV_RUN) begin
      if (!div_diff[33]) begin
        rem_q <= div_diff[31:0];
        quo_q <= {quo_q[30:0], 1'b1};
      end else begin
        rem_q <= div_shift[31:0];
        quo_q <= {quo_q[30:0], 1'b0};
      end
    end
  end

  // Divide by zero forces all ones; remainder comes out as the dividend.
  // Overflow case lands on the dividend and zero without help
  assign div_quo    = div_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  assign div_rem    = neg_rem_q ? -rem_q : rem_q;
  assign div_result = is_rem_q ? div_rem : div_quo;

  // ------------------------------------------------------------
  // Response register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (resp_free) begin
      resp_valid_q <= m1_valid_q || (state_q == DIV_DONE);
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp_free && m1_valid_q) begin
      resp_data_q <= mul_result;
      resp_id_q   <= m1_id_q;
    end else if (resp_free && (state_q == DIV_DONE)) begin
      resp_data_q <= div_result;
      resp_id_q   <= div_id_q;
    end
  end

  assign pvalid_o = resp_valid_q;
  assign pdata_o  = resp_data_q;
  assign pid_o    = resp_id_q;

  // Unit stays closed for the whole division
  assert property (@(posedge clk_i) disable iff (rst_i)
    div_fire |=> !(qvalid_i && qready_o) [*33]);

  assert property (@(posedge clk_i) disable iff (rst_i)
    pvalid_o && !pready_i |=> pvalid_o && $stable(pdata_o) && $stable(pid_o));

endmodule

// File: hdl/ipu_pkg.sv
// Shared definitions for the multiply/divide offload complex
// Opcode enum, tag width, counter width and packed channel widths

package ipu_pkg;

  // ------------------------------------------------------------
  // RV32M operations
  // ------------------------------------------------------------
  // Bit 2 set marks the division group
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } ipu_op_e;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  // Offload tag
  localparam int unsigned IdWidth = 5;

  // Event counters
  localparam int unsigned CountWidth = 16;

  // Request word is {op, arga, argb, id}
  localparam int unsigned ReqWidth = 3 + 32 + 32 + IdWidth;

  // Response word is {data, id}
  localparam int unsigned RespWidth = 32 + IdWidth;

endpackage

// File: hdl/offload_counters.sv
// Saturating event counters for the offload port

`timescale 1ns/1ps

module offload_counters import ipu_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_fire_i,
  input  logic                  req_stall_i,
  input  logic                  resp_fire_i,
  input  logic                  cnt_clear_i,
  output logic [CountWidth-1:0] cnt_req_o,
  output logic [CountWidth-1:0] cnt_resp_o,
  output logic [CountWidth-1:0] cnt_stall_o
);

  logic [2:0]            inc;
  logic [CountWidth-1:0] cnt_q [3];
  logic                  cleared_q;

  // Slot order: requests, stalls, responses
  assign inc = {resp_fire_i, req_stall_i, req_fire_i};

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 3; i++) begin
        // Clear beats a same-cycle event
        if (cnt_clear_i) begin
          cnt_q[i] <= '0;
        end else if (inc[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_req_o   = cnt_q[0];
  assign cnt_stall_o = cnt_q[1];
  assign cnt_resp_o  = cnt_q[2];

  // Remembers a clear, after which in-flight responses can outrun requests
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cleared_q <= 1'b0;
    end else if (cnt_clear_i) begin
      cleared_q <= 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (rst_i)
    !cleared_q |-> cnt_resp_o <= cnt_req_o);

endmodule

// File: hdl/spill_register.sv
// Two-entry valid/ready register slice with optional bypass

`timescale 1ns/1ps

module spill_register #(
  parameter int unsigned Width  = 32,
  parameter bit          Bypass = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic [Width-1:0] data_i,
  output logic             ready_o,
  output logic             valid_o,
  output logic [Width-1:0] data_o,
  input  logic             ready_i
);

  if (Bypass) begin : gen_bypass
    assign valid_o = valid_i;
    assign data_o  = data_i;
    assign ready_o = ready_i;
  end else begin : gen_spill
    logic             a_full_q, b_full_q;
    logic [Width-1:0] a_data_q, b_data_q;
    logic             a_fill, a_drain, b_fill, b_drain;

    // A takes new items, B catches A when downstream stalls
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill || a_drain) begin
          a_full_q <= a_fill;
        end
        if (b_fill || b_drain) begin
          b_full_q <= b_fill;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= data_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    // Ready only looks at register state
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    // B always holds the older item
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    assert property (@(posedge clk_i) disable iff (rst_i)
      valid_o && !ready_i |=> valid_o && $stable(data_o));
  end

endmodule

// File: ipu_cc.f
hdl/ipu_pkg.sv
hdl/spill_register.sv
hdl/ipu_muldiv.sv
hdl/offload_counters.sv
hdl/ipu_cc.sv
verif/tb_clock_gen.sv
verif/ipu_cc_checker.sv
verif/ipu_cc_tb.sv

// File: verif/ipu_cc_checker.sv
// Offload monitor with the RV32M reference model,
// in-order response comparison and counter checks

`timescale 1ns/1ps

module ipu_cc_checker import ipu_pkg::*; #(
  parameter int unsigned NumOps = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  ipu_op_e               qop_i,
  input  logic [31:0]           qarga_i,
  input  logic [31:0]           qargb_i,
  input  logic [IdWidth-1:0]    qid_i,
  input  logic                  qvalid_i,
  input  logic                  qready_i,
  input  logic [31:0]           pdata_i,
  input  logic [IdWidth-1:0]    pid_i,
  input  logic                  pvalid_i,
  input  logic                  pready_i,
  input  logic                  cnt_clear_i,
  input  logic [CountWidth-1:0] cnt_req_i,
  input  logic [CountWidth-1:0] cnt_resp_i,
  input  logic [CountWidth-1:0] cnt_stall_i,
  input  logic                  final_check_i,
  output int                    pending_o,
  output int                    checked_o,
  output int                    data_errs_o,
  output int                    id_errs_o,
  output int                    cnt_errs_o,
  output int                    other_errs_o
);

  logic [31:0]        exp_data_q[$];
  logic [IdWidth-1:0] exp_id_q[$];
  ipu_op_e            exp_op_q[$];
  logic [31:0]        exp_data;
  logic [IdWidth-1:0] exp_id;
  ipu_op_e            exp_op;
  int pending = 0;
  int checked = 0;
  int req_seen = 0;
  int resp_seen = 0;
  int stall_seen = 0;
  int data_errs = 0;
  int id_errs = 0;
  int cnt_errs = 0;
  int other_errs = 0;
  bit after_reset = 1'b0;
  bit clear_seen = 1'b0;
  bit final_done = 1'b0;

  assign pending_o    = pending;
  assign checked_o    = checked;
  assign data_errs_o  = data_errs;
  assign id_errs_o    = id_errs;
  assign cnt_errs_o   = cnt_errs;
  assign other_errs_o = other_errs;

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] rv32m_result(ipu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    logic        overflow;
    ext_a = {32'd0, a};
    ext_b = {32'd0, b};
    if (op == OP_MULH || op == OP_MULHSU) begin
      ext_a = {{32{a[31]}}, a};
    end
    if (op == OP_MULH) begin
      ext_b = {{32{b[31]}}, b};
    end
    // Low 64 bits of the extended product are exact for every sign mix
    prod     = ext_a * ext_b;
    overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (op)
      OP_MUL:                       return prod[31:0];
      OP_MULH, OP_MULHSU, OP_MULHU: return prod[63:32];
      OP_DIV: begin
        if (b == 32'd0) return 32'hffff_ffff;
        if (overflow) return a;
        return $signed(a) / $signed(b);
      end
      OP_DIVU: begin
        if (b == 32'd0) return 32'hffff_ffff;
        return a / b;
      end
      OP_REM: begin
        if (b == 32'd0) return a;
        if (overflow) return 32'd0;
        return $signed(a) % $signed(b);
      end
      OP_REMU: begin
        if (b == 32'd0) return a;
        return a % b;
      end
      default: return 32'd0;
    endcase
  endfunction

  task automatic check_counter(string name, logic [CountWidth-1:0] got, int expected);
    if (got !== CountWidth'(expected)) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
      cnt_errs++;
    end
  endtask

  // ------------------------------------------------------------
  // Monitor, sampled mid-cycle where every input is settled
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    if (rst_i) begin
      exp_data_q.delete();
      exp_id_q.delete();
      exp_op_q.delete();
      pending    = 0;
      req_seen   = 0;
      resp_seen  = 0;
      stall_seen = 0;
      after_reset = 1'b1;
    end else begin
      if (after_reset) begin
        if (pvalid_i) begin
          $display("offload_pvalid_o is high right after reset at %0t", $time);
          other_errs++;
        end
        check_counter("cnt_req_o", cnt_req_i, 0);
        check_counter("cnt_resp_o", cnt_resp_i, 0);
        check_counter("cnt_stall_o", cnt_stall_i, 0);
        after_reset = 1'b0;
      end
      // One cycle after a clear strobe
      if (clear_seen) begin
        check_counter("cnt_req_o", cnt_req_i, 0);
        check_counter("cnt_resp_o", cnt_resp_i, 0);
        check_counter("cnt_stall_o", cnt_stall_i, 0);
        clear_seen = 1'b0;
      end

      if (qvalid_i && qready_i) begin
        exp_data_q.push_back(rv32m_result(qop_i, qarga_i, qargb_i));
        exp_id_q.push_back(qid_i);
        exp_op_q.push_back(qop_i);
        req_seen++;
      end
      if (qvalid_i && !qready_i) begin
        stall_seen++;
      end

      if (pvalid_i && pready_i) begin
        resp_seen++;
        if (exp_data_q.size() == 0) begin
          $display("response with id %0d at %0t has no outstanding request", pid_i, $time);
          other_errs++;
        end else begin
          exp_data = exp_data_q.pop_front();
          exp_id   = exp_id_q.pop_front();
          exp_op   = exp_op_q.pop_front();
          checked++;
          if (pid_i !== exp_id) begin
            $display("mismatch at %0t: offload_pid_o got %0d expected %0d",
                     $time, pid_i, exp_id);
            id_errs++;
          end
          if (pdata_i !== exp_data) begin
            $display("mismatch at %0t: offload_pdata_o got %h expected %h (%s)",
                     $time, pdata_i, exp_data, exp_op.name());
            data_errs++;
          end
        end
      end
      pending = exp_data_q.size();

      // Clear wins over this cycle's events
      if (cnt_clear_i) begin
        req_seen   = 0;
        resp_seen  = 0;
        stall_seen = 0;
        clear_seen = 1'b1;
      end

      if (final_check_i && !final_done) begin
        if (pending != 0) begin
          $display("%0d requests never got a response", pending);
          other_errs++;
        end
        if (checked != NumOps) begin
          $display("expected %0d responses but %0d arrived", NumOps, checked);
          other_errs++;
        end
        check_counter("cnt_req_o", cnt_req_i, req_seen);
        check_counter("cnt_resp_o", cnt_resp_i, resp_seen);
        check_counter("cnt_stall_o", cnt_stall_i, stall_seen);
        final_done = 1'b1;
      end
    end
  end

endmodule

// File: verif/ipu_cc_tb.sv
// Testbench top with the DUT, the checker, LFSR-driven offload
// traffic and the watchdog

`timescale 1ns/1ps

module ipu_cc_tb import ipu_pkg::*; ();

  localparam int unsigned ClkPeriod     = 8;
  localparam int unsigned NumMul        = 120;
  localparam int unsigned NumDiv        = 60;
  localparam int unsigned NumMixed      = 120;
  localparam int unsigned NumDirected   = 4;
  localparam int unsigned NumOps        = NumMul + NumDiv + NumMixed + NumDirected;
  localparam int unsigned DrainCycles   = 400;
  localparam int unsigned TimeoutCycles = NumOps * 40 + 2000;

  logic                  clk;
  logic                  rst;
  ipu_op_e               offload_qop;
  logic [31:0]           offload_qarga;
  logic [31:0]           offload_qargb;
  logic [IdWidth-1:0]    offload_qid;
  logic                  offload_qvalid;
  logic                  offload_qready;
  logic [31:0]           offload_pdata;
  logic [IdWidth-1:0]    offload_pid;
  logic                  offload_pvalid;
  logic                  offload_pready;
  logic                  cnt_clear;
  logic [CountWidth-1:0] cnt_req;
  logic [CountWidth-1:0] cnt_resp;
  logic [CountWidth-1:0] cnt_stall;
  logic                  final_check;
  int pending, checked, data_errs, id_errs, cnt_errs, other_errs, total_errs;
  logic [15:0]           lfsr_q = 16'd43;
  bit                    ready_random = 1'b0;

  tb_clock_gen #(
    .Period      ( ClkPeriod ),
    .ResetCycles ( 10        )
  ) i_clock_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  ipu_cc #(
    .RegisterOffloadReq  ( 1'b1 ),
    .RegisterOffloadResp ( 1'b1 )
  ) i_dut (
    .clk_i            ( clk            ),
    .rst_i            ( rst            ),
    .offload_qop_i    ( offload_qop    ),
    .offload_qarga_i  ( offload_qarga  ),
    .offload_qargb_i  ( offload_qargb  ),
    .offload_qid_i    ( offload_qid    ),
    .offload_qvalid_i ( offload_qvalid ),
    .offload_qready_o ( offload_qready ),
    .offload_pdata_o  ( offload_pdata  ),
    .offload_pid_o    ( offload_pid    ),
    .offload_pvalid_o ( offload_pvalid ),
    .offload_pready_i ( offload_pready ),
    .cnt_clear_i      ( cnt_clear      ),
    .cnt_req_o        ( cnt_req        ),
    .cnt_resp_o       ( cnt_resp       ),
    .cnt_stall_o      ( cnt_stall      )
  );

  ipu_cc_checker #(
    .NumOps ( NumOps )
  ) i_checker (
    .clk_i         ( clk            ),
    .rst_i         ( rst            ),
    .qop_i         ( offload_qop    ),
    .qarga_i       ( offload_qarga  ),
    .qargb_i       ( offload_qargb  ),
    .qid_i         ( offload_qid    ),
    .qvalid_i      ( offload_qvalid ),
    .qready_i      ( offload_qready ),
    .pdata_i       ( offload_pdata  ),
    .pid_i         ( offload_pid    ),
    .pvalid_i      ( offload_pvalid ),
    .pready_i      ( offload_pready ),
    .cnt_clear_i   ( cnt_clear      ),
    .cnt_req_i     ( cnt_req        ),
    .cnt_resp_i    ( cnt_resp       ),
    .cnt_stall_i   ( cnt_stall      ),
    .final_check_i ( final_check    ),
    .pending_o     ( pending        ),
    .checked_o     ( checked        ),
    .data_errs_o   ( data_errs      ),
    .id_errs_o     ( id_errs        ),
    .cnt_errs_o    ( cnt_errs       ),
    .other_errs_o  ( other_errs     )
  );

  // ------------------------------------------------------------
  // Random source, x^16 + x^14 + x^13 + x^11 + 1
  // ------------------------------------------------------------
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw(input int unsigned n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[15]};
    end
  endtask

  // Advance to 1 ns after the next rising edge
  task automatic next_cycle();
    logic [31:0] r;
    @(posedge clk);
    #1;
    if (ready_random) begin
      draw(2, r);
      offload_pready = (r[1:0] != 2'd0);
    end else begin
      offload_pready = 1'b1;
    end
  endtask

  task automatic send_req(input ipu_op_e op, input logic [31:0] a, input logic [31:0] b);
    offload_qop    = op;
    offload_qarga  = a;
    offload_qargb  = b;
    offload_qvalid = 1'b1;
    @(negedge clk);
    while (!offload_qready) begin
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    offload_qvalid = 1'b0;
    offload_qid    = offload_qid + 1'b1;
  endtask

  // Mode 0 multiplies, 1 divides, anything else mixes both
  task automatic random_req(input int unsigned mode);
    logic [31:0] r_op;
    logic [31:0] r_sel;
    logic [31:0] r_gap;
    logic [31:0] a;
    logic [31:0] b;
    ipu_op_e     op;
    if (mode == 0) begin
      draw(2, r_op);
      op = ipu_op_e'({1'b0, r_op[1:0]});
    end else if (mode == 1) begin
      draw(2, r_op);
      op = ipu_op_e'({1'b1, r_op[1:0]});
    end else begin
      draw(3, r_op);
      op = ipu_op_e'(r_op[2:0]);
    end
    draw(32, a);
    draw(32, b);
    draw(3, r_sel);
    case (r_sel[2:0])
      3'd0: b = 32'd0;
      3'd1: begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      3'd2: b = {28'd0, b[3:0]};
      3'd3: a = {24'd0, a[7:0]};
      default: ;
    endcase
    send_req(op, a, b);
    draw(2, r_gap);
    if (r_gap[1:0] == 2'd0) begin
      draw(2, r_gap);
      repeat (r_gap[1:0] + 1) next_cycle();
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    offload_qop    = OP_MUL;
    offload_qarga  = '0;
    offload_qargb  = '0;
    offload_qid    = '0;
    offload_qvalid = 1'b0;
    offload_pready = 1'b1;
    cnt_clear      = 1'b0;
    final_check    = 1'b0;
    @(negedge rst);
    repeat (3) next_cycle();

    repeat (NumMul) random_req(0);

    // Overflow and divide by zero first
    send_req(OP_DIV, 32'h8000_0000, 32'hffff_ffff);
    send_req(OP_REM, 32'h8000_0000, 32'hffff_ffff);
    send_req(OP_DIVU, 32'h1234_5678, 32'd0);
    send_req(OP_REM, 32'hfedc_ba98, 32'd0);
    repeat (NumDiv) random_req(1);

    // Back-pressure on responses, counters cleared halfway
    ready_random = 1'b1;
    for (int i = 0; i < NumMixed; i++) begin
      if (i == NumMixed / 2) begin
        cnt_clear = 1'b1;
        next_cycle();
        cnt_clear = 1'b0;
      end
      random_req(2);
    end

    // Bounded drain of the outstanding responses
    for (int w = 0; (w < DrainCycles) && (pending != 0); w++) begin
      next_cycle();
    end
    ready_random = 1'b0;
    repeat (4) next_cycle();
    final_check = 1'b1;
    next_cycle();
    final_check = 1'b0;
    next_cycle();

    total_errs = data_errs + id_errs + cnt_errs + other_errs;
    $display("errors: data %0d, id %0d, counter %0d, other %0d (%0d responses checked)",
             data_errs, id_errs, cnt_errs, other_errs, checked);
    if (total_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
    $display("tests failed");
    $finish;
  end

endmodule

// File: verif/tb_clock_gen.sv
// Testbench clock and reset generator

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned Period      = 8,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2.0) clk_o = ~clk_o;
  end

  // Release just after an edge, like the rest of the stimulus
  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule
